//--- verilog/memLink_consts.svh
`ifndef MEMLINK_CONSTS_SVH
`define MEMLINK_CONSTS_SVH

// Data word carried by one packet
`define MEMLINK_WORD_WIDTH 36

// 1024-word shared RAM
`define MEMLINK_ADDR_WIDTH 10

// Word plus a 2-bit tag on each half
`define MEMLINK_PACKET_WIDTH (`MEMLINK_WORD_WIDTH + 4)

// Links sharing the RAM
`define MEMLINK_NUM_PORTS 2

// Queue depth per port in the arbiter, also initial credits
`define MEMLINK_CREDITS 2

// Tag pairs for first and second half
`define MEMLINK_TAG_HI 2'b01
`define MEMLINK_TAG_LO 2'b10

`endif

//--- verilog/memPkg.sv
`default_nettype none

`include "memLink_consts.svh"

package memPkg;

    typedef logic [`MEMLINK_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`MEMLINK_WORD_WIDTH-1:0] word_t;

    // One RAM access per accepted strobe
    // Read always happens, write only with wrEn
    typedef struct packed {
        addr_t rdAddr;
        logic  wrEn;
        addr_t wrAddr;
        word_t wrData;
    } memReq_t;

    // Registered read result
    typedef struct packed {
        word_t rdData;
    } memResp_t;

endpackage

`default_nettype wire

//--- verilog/linkPkg.sv
`default_nettype none

`include "memLink_consts.svh"

package linkPkg;

    // Data bits in one half, after its tag
    localparam int HalfWidth = `MEMLINK_PACKET_WIDTH / 2 - 2;

    // One half of a packet, tag in the top two bits
    typedef struct packed {
        logic [1:0]           tag;
        logic [HalfWidth-1:0] data;
    } half_t;

    // First half sits in the upper bits
    typedef struct packed {
        half_t first;
        half_t second;
    } packet_t;

endpackage

`default_nettype wire

//--- verilog/linkMemPort.sv
`default_nettype none

`include "memLink_consts.svh"

module linkMemPort (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    restart,
    input  wire                    dataReady,
    input  wire linkPkg::packet_t  inPacket,
    output linkPkg::packet_t       outPacket,
    output logic                   outValid,
    output logic                   inPacketIsValid,
    output logic                   overflow,
    output logic                   reqValid,
    output memPkg::memReq_t        req,
    input  wire                    creditReturn,
    input  wire                    respValid,
    input  wire memPkg::memResp_t  resp
);

    localparam int CreditWidth = $clog2(`MEMLINK_CREDITS + 1);
    localparam int HalfWidth = linkPkg::HalfWidth;

    typedef enum logic [1:0] {
        GetReadAddr,
        GetWriteAddr,
        Streaming
    } state_t;

    state_t                 state;
    memPkg::word_t          inWord;
    memPkg::addr_t          inAddr;
    memPkg::addr_t          readAddr;
    memPkg::addr_t          writeAddr;
    logic [CreditWidth-1:0] credits;
    logic                   accept;
    logic                   drop;
    memPkg::memReq_t        nextReq;
    linkPkg::packet_t       respPacket;

    // Tag check, both pairs must match
    assign inPacketIsValid = (inPacket.first.tag == `MEMLINK_TAG_HI) &&
                             (inPacket.second.tag == `MEMLINK_TAG_LO);

    // Strip tags and rejoin the halves
    assign inWord = {inPacket.first.data, inPacket.second.data};
    assign inAddr = inWord[`MEMLINK_ADDR_WIDTH-1:0];

    // Restart wins over a strobe in the same cycle
    assign accept = dataReady && !restart && (credits != '0);
    // No credit left, strobe is lost
    assign drop = dataReady && !restart && (credits == '0);

    // Request for the current strobe
    always_comb begin
        nextReq = '0;
        nextReq.wrAddr = writeAddr;
        nextReq.wrData = inWord;
        unique case (state)
            GetReadAddr: begin
                // First read comes straight from the packet
                nextReq.rdAddr = inAddr;
            end
            GetWriteAddr: begin
                nextReq.rdAddr = readAddr;
            end
            default: begin
                nextReq.rdAddr = readAddr;
                // Invalid packets only read
                nextReq.wrEn = inPacketIsValid;
            end
        endcase
    end

    // Sequencer state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= GetReadAddr;
        end else if (restart) begin
            state <= GetReadAddr;
        end else if (accept) begin
            unique case (state)
                GetReadAddr:  state <= GetWriteAddr;
                GetWriteAddr: state <= Streaming;
                default:      state <= Streaming;
            endcase
        end
    end

    // Address counters and request payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req <= nextReq;
            unique case (state)
                GetReadAddr: begin
                    readAddr <= inAddr + 1'b1;
                end
                GetWriteAddr: begin
                    readAddr <= readAddr + 1'b1;
                    writeAddr <= inAddr;
                end
                default: begin
                    readAddr <= readAddr + 1'b1;
                    // Advances even past an invalid packet
                    writeAddr <= writeAddr + 1'b1;
                end
            endcase
        end
    end

    // Credits, request strobe and sticky overflow
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= CreditWidth'(`MEMLINK_CREDITS);
            reqValid <= 1'b0;
            overflow <= 1'b0;
        end else begin
            reqValid <= accept;
            credits <= credits - CreditWidth'(accept) + CreditWidth'(creditReturn);
            if (restart) begin
                overflow <= 1'b0;
            end else if (drop) begin
                overflow <= 1'b1;
            end
        end
    end

    // Re-tag the returned word
    assign respPacket = {
        `MEMLINK_TAG_HI, resp.rdData[`MEMLINK_WORD_WIDTH-1:HalfWidth],
        `MEMLINK_TAG_LO, resp.rdData[HalfWidth-1:0]
    };

    // Output packet holds until the next response
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            outValid <= 1'b0;
            outPacket <= '0;
        end else begin
            outValid <= respValid;
            if (respValid) begin
                outPacket <= respPacket;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/memArbiter.sv
`default_nettype none

`include "memLink_consts.svh"

module memArbiter (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire [`MEMLINK_NUM_PORTS-1:0]           reqValid,
    input  wire memPkg::memReq_t                   req [`MEMLINK_NUM_PORTS],
    output logic [`MEMLINK_NUM_PORTS-1:0]          creditReturn,
    output logic [`MEMLINK_NUM_PORTS-1:0]          respValid,
    output memPkg::memResp_t                       resp,
    output logic                                   ramReqValid,
    output memPkg::memReq_t                        ramReq,
    input  wire memPkg::memResp_t                  ramResp
);

    localparam int NumPorts = `MEMLINK_NUM_PORTS;
    localparam int Depth = `MEMLINK_CREDITS;
    localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);
    localparam int PortWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

    memPkg::memReq_t       queue [NumPorts][Depth];
    logic [PtrWidth-1:0]   wrPtr [NumPorts];
    logic [PtrWidth-1:0]   rdPtr [NumPorts];
    logic [CountWidth-1:0] count [NumPorts];
    logic [PortWidth-1:0]  lastGrant;
    logic [PortWidth-1:0]  grantPort;
    logic                  grantValid;
    logic [PortWidth-1:0]  respPort;
    logic                  respPending;

    // Round robin, search starts just past the last winner
    always_comb begin
        int cand;
        grantValid = 1'b0;
        grantPort = lastGrant;
        for (int k = 1; k <= NumPorts; k++) begin
            cand = (int'(lastGrant) + k) % NumPorts;
            if (!grantValid && count[cand] != '0) begin
                grantValid = 1'b1;
                grantPort = PortWidth'(cand);
            end
        end
    end

    assign ramReqValid = grantValid;
    assign ramReq = queue[grantPort][rdPtr[grantPort]];

    // Credit goes back the cycle the entry leaves the queue
    always_comb begin
        creditReturn = '0;
        if (grantValid) begin
            creditReturn[grantPort] = 1'b1;
        end
    end

    // Queue storage
    always_ff @(posedge clk) begin
        for (int p = 0; p < NumPorts; p++) begin
            if (reqValid[p]) begin
                queue[p][wrPtr[p]] <= req[p];
            end
        end
    end

    // Queue pointers, counts and grant history
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int p = 0; p < NumPorts; p++) begin
                wrPtr[p] <= '0;
                rdPtr[p] <= '0;
                count[p] <= '0;
            end
            // Port 0 wins first
            lastGrant <= PortWidth'(NumPorts - 1);
            respPending <= 1'b0;
            respPort <= '0;
        end else begin
            for (int p = 0; p < NumPorts; p++) begin
                if (reqValid[p]) begin
                    wrPtr[p] <= (wrPtr[p] == PtrWidth'(Depth - 1)) ? '0 : wrPtr[p] + 1'b1;
                end
                if (creditReturn[p]) begin
                    rdPtr[p] <= (rdPtr[p] == PtrWidth'(Depth - 1)) ? '0 : rdPtr[p] + 1'b1;
                end
                count[p] <= count[p] + CountWidth'(reqValid[p])
                            - CountWidth'(creditReturn[p]);
            end
            if (grantValid) begin
                lastGrant <= grantPort;
            end
            // Remember who owns the RAM output next cycle
            respPending <= grantValid;
            respPort <= grantPort;
        end
    end

    // Read data is shared, the valid is steered
    assign resp = ramResp;

    always_comb begin
        respValid = '0;
        if (respPending) begin
            respValid[respPort] = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sharedRam.sv
`default_nettype none

`include "memLink_consts.svh"

module sharedRam (
    input  wire                    clk,
    input  wire                    ramReqValid,
    input  wire memPkg::memReq_t   ramReq,
    output memPkg::memResp_t       ramResp
);

    localparam int Depth = 1 << `MEMLINK_ADDR_WIDTH;

    memPkg::word_t mem [Depth];

    // Write and read on the same edge
    // Nonblocking read sees the old word, read-first
    always_ff @(posedge clk) begin
        if (ramReqValid) begin
            if (ramReq.wrEn) begin
                mem[ramReq.wrAddr] <= ramReq.wrData;
            end
            ramResp.rdData <= mem[ramReq.rdAddr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/memLinkTop.sv
`default_nettype none

`include "memLink_consts.svh"

module memLinkTop (
    input  wire                              clk,
    input  wire                              reset,
    input  wire [`MEMLINK_NUM_PORTS-1:0]     dataReady,
    input  wire [`MEMLINK_NUM_PORTS-1:0]     restart,
    input  wire linkPkg::packet_t            inPacket [`MEMLINK_NUM_PORTS],
    output linkPkg::packet_t                 outPacket [`MEMLINK_NUM_PORTS],
    output logic [`MEMLINK_NUM_PORTS-1:0]    outValid,
    output logic [`MEMLINK_NUM_PORTS-1:0]    inPacketIsValid,
    output logic [`MEMLINK_NUM_PORTS-1:0]    overflow
);

    // Credit channel between links and arbiter
    logic [`MEMLINK_NUM_PORTS-1:0] reqValid;
    memPkg::memReq_t               req [`MEMLINK_NUM_PORTS];
    logic [`MEMLINK_NUM_PORTS-1:0] creditReturn;
    logic [`MEMLINK_NUM_PORTS-1:0] respValid;
    memPkg::memResp_t              resp;

    // Arbiter to RAM
    logic                          ramReqValid;
    memPkg::memReq_t               ramReq;
    memPkg::memResp_t              ramResp;

    // One link port per serial link
    for (genvar i = 0; i < `MEMLINK_NUM_PORTS; i++) begin : genLink
        linkMemPort linkPort (
            .clk             (clk),
            .reset           (reset),
            .restart         (restart[i]),
            .dataReady       (dataReady[i]),
            .inPacket        (inPacket[i]),
            .outPacket       (outPacket[i]),
            .outValid        (outValid[i]),
            .inPacketIsValid (inPacketIsValid[i]),
            .overflow        (overflow[i]),
            .reqValid        (reqValid[i]),
            .req             (req[i]),
            .creditReturn    (creditReturn[i]),
            .respValid       (respValid[i]),
            .resp            (resp)
        );
    end

    memArbiter arbiter (
        .clk          (clk),
        .reset        (reset),
        .reqValid     (reqValid),
        .req          (req),
        .creditReturn (creditReturn),
        .respValid    (respValid),
        .resp         (resp),
        .ramReqValid  (ramReqValid),
        .ramReq       (ramReq),
        .ramResp      (ramResp)
    );

    sharedRam ram (
        .clk         (clk),
        .ramReqValid (ramReqValid),
        .ramReq      (ramReq),
        .ramResp     (ramResp)
    );

endmodule

`default_nettype wire

//--- sim/memLinkTb.sv
`default_nettype none

`include "memLink_consts.svh"

module memLinkTb;

    localparam int NumLinks = `MEMLINK_NUM_PORTS;
    localparam int MemDepth = 1 << `MEMLINK_ADDR_WIDTH;
    localparam int Half = `MEMLINK_WORD_WIDTH / 2;
    localparam int HalfPeriod = 20;
    localparam int MaxRows = 32;
    localparam int Slots = 4;
    // Worst case strobe to outValid, in cycles
    localparam int MaxLatency = 2 + 2 * `MEMLINK_NUM_PORTS;
    localparam int Gap = 10;
    // Rows spaced at least this far get their responses drained
    localparam int SpacedGap = 8;
    // Row kinds: address word, random data word, raw packet
    localparam int KAddr = 0;
    localparam int KData = 1;
    localparam int KRaw = 2;

    logic                clk;
    logic                reset;
    logic [NumLinks-1:0] dataReady;
    logic [NumLinks-1:0] restart;
    linkPkg::packet_t    inPacket [NumLinks];
    linkPkg::packet_t    outPacket [NumLinks];
    logic [NumLinks-1:0] outValid;
    logic [NumLinks-1:0] inPacketIsValid;
    logic [NumLinks-1:0] overflow;

    // Stimulus and expected values, one row per strobe
    string                            rowName [MaxRows];
    int                               rowLink [MaxRows];
    bit                               rowRestart [MaxRows];
    int                               rowKind [MaxRows];
    logic [`MEMLINK_PACKET_WIDTH-1:0] rowValue [MaxRows];
    int                               rowGap [MaxRows];
    bit                               rowDrop [MaxRows];
    bit                               rowOvf [MaxRows];
    bit                               rowFailed [MaxRows];
    int                               numRows;
    int                               maxGap;

    // Reference memory and per-link sequencer
    memPkg::word_t model [MemDepth];
    bit            known [MemDepth];
    int            seqCount [NumLinks];
    memPkg::addr_t rdPtr [NumLinks];
    memPkg::addr_t wrPtr [NumLinks];

    // Outstanding responses per link, oldest at head
    linkPkg::packet_t expPkt [NumLinks][Slots];
    bit               expKnown [NumLinks][Slots];
    int               expRow [NumLinks][Slots];
    int               head [NumLinks];
    int               tail [NumLinks];

    integer seed;
    int     passCount;
    int     failCount;
    int     strayCount;
    int     reported;
    bit     resetFailed;
    int     monSlot;

    memLinkTop UUT (
        .clk             (clk),
        .reset           (reset),
        .dataReady       (dataReady),
        .restart         (restart),
        .inPacket        (inPacket),
        .outPacket       (outPacket),
        .outValid        (outValid),
        .inPacketIsValid (inPacketIsValid),
        .overflow        (overflow)
    );

    always #HalfPeriod clk = ~clk;

    // Tag pairs around the two halves
    function automatic linkPkg::packet_t makePacket(input memPkg::word_t word);
        linkPkg::packet_t pkt;
        pkt.first.tag = `MEMLINK_TAG_HI;
        pkt.first.data = word[`MEMLINK_WORD_WIDTH-1:Half];
        pkt.second.tag = `MEMLINK_TAG_LO;
        pkt.second.data = word[Half-1:0];
        return pkt;
    endfunction

    function automatic bit tagsValid(input linkPkg::packet_t pkt);
        return (pkt.first.tag == `MEMLINK_TAG_HI) && (pkt.second.tag == `MEMLINK_TAG_LO);
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual, inout bit failed);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            failed = 1'b1;
        end
    endtask

    task automatic addRow(input string name, input int link, input bit rst, input int kind,
                          input logic [`MEMLINK_PACKET_WIDTH-1:0] value, input int gap,
                          input bit drop, input bit ovf);
        rowName[numRows] = name;
        rowLink[numRows] = link;
        rowRestart[numRows] = rst;
        rowKind[numRows] = kind;
        rowValue[numRows] = value;
        rowGap[numRows] = gap;
        rowDrop[numRows] = drop;
        rowOvf[numRows] = ovf;
        rowFailed[numRows] = 1'b0;
        if (gap > maxGap) begin
            maxGap = gap;
        end
        numRows++;
    endtask

    task automatic buildTable();
        // Link 0 fills 0x010 to 0x012 with A = W
        addRow("wrSeqRdAddr", 0, 1, KAddr, 'h010, Gap, 0, 0);
        addRow("wrSeqWrAddr", 0, 0, KAddr, 'h010, Gap, 0, 0);
        addRow("wrSeqData0", 0, 0, KData, 'h0, Gap, 0, 0);
        addRow("wrSeqData1", 0, 0, KData, 'h0, Gap, 0, 0);
        addRow("wrSeqData2", 0, 0, KData, 'h0, Gap, 0, 0);
        // Read back, invalid packet aimed at 0x011
        addRow("backRdAddr", 0, 1, KAddr, 'h010, Gap, 0, 0);
        addRow("backWrAddr", 0, 0, KAddr, 'h011, Gap, 0, 0);
        addRow("invalidData", 0, 0, KRaw,
               {`MEMLINK_TAG_LO, 18'h01234, `MEMLINK_TAG_HI, 18'h05678}, Gap, 0, 0);
        addRow("afterInvalid", 0, 0, KData, 'h0, Gap, 0, 0);
        // 0x011 unchanged, 0x012 holds the word after the invalid one
        addRow("invalidRdAddr", 0, 1, KAddr, 'h011, Gap, 0, 0);
        addRow("invalidWrAddr", 0, 0, KAddr, 'h3f0, Gap, 0, 0);
        // Both links stream in the same cycles into 0x100 and 0x200
        addRow("shareRd0", 0, 1, KAddr, 'h050, 1, 0, 0);
        addRow("shareRd1", 1, 1, KAddr, 'h060, Gap - 1, 0, 0);
        addRow("shareWr0", 0, 0, KAddr, 'h100, 0, 0, 0);
        addRow("shareWr1", 1, 0, KAddr, 'h200, Gap, 0, 0);
        addRow("shareData0a", 0, 0, KData, 'h0, 0, 0, 0);
        addRow("shareData1a", 1, 0, KData, 'h0, Gap, 0, 0);
        addRow("shareData0b", 0, 0, KData, 'h0, 0, 0, 0);
        addRow("shareData1b", 1, 0, KData, 'h0, Gap, 0, 0);
        // Each link reads the other one's region
        addRow("crossRd0", 0, 1, KAddr, 'h200, 1, 0, 0);
        addRow("crossRd1", 1, 1, KAddr, 'h100, Gap - 1, 0, 0);
        addRow("crossWr0", 0, 0, KAddr, 'h3e0, 0, 0, 0);
        addRow("crossWr1", 1, 0, KAddr, 'h3d0, Gap, 0, 0);
        // Third back-to-back strobe finds no credit
        addRow("ovfRdAddr", 1, 1, KAddr, 'h0ff, 1, 0, 0);
        addRow("ovfWrAddr", 1, 0, KAddr, 'h080, 1, 0, 0);
        addRow("ovfDrop", 1, 0, KData, 'h0, Gap, 1, 1);
        addRow("ovfResume", 1, 0, KData, 'h0, Gap, 0, 1);
        // Restart mid-stream, back to a read address
        addRow("restartRd", 1, 1, KAddr, 'h010, Gap, 0, 0);
        addRow("restartWr", 1, 0, KAddr, 'h090, Gap, 0, 0);
        addRow("restartData", 1, 0, KData, 'h0, Gap, 0, 0);
    endtask

    // Sequence rule for one accepted strobe
    task automatic modelStrobe(input int row, input linkPkg::packet_t pkt);
        int            l;
        int            slot;
        memPkg::word_t word;
        memPkg::addr_t rd;
        l = rowLink[row];
        word = {pkt.first.data, pkt.second.data};
        seqCount[l]++;
        if (seqCount[l] == 1) begin
            rd = word[`MEMLINK_ADDR_WIDTH-1:0];
        end else begin
            rd = rdPtr[l];
        end
        rdPtr[l] = rd + 1'b1;
        slot = tail[l] % Slots;
        expRow[l][slot] = row;
        expKnown[l][slot] = known[rd];
        expPkt[l][slot] = makePacket(model[rd]);
        tail[l]++;
        // Read-first, write lands after the read
        if (seqCount[l] == 2) begin
            wrPtr[l] = word[`MEMLINK_ADDR_WIDTH-1:0];
        end else if (seqCount[l] >= 3) begin
            if (tagsValid(pkt)) begin
                model[wrPtr[l]] = word;
                known[wrPtr[l]] = 1'b1;
            end
            wrPtr[l] = wrPtr[l] + 1'b1;
        end
    endtask

    task automatic applyRow(input int i);
        int               l;
        int               r1;
        int               r2;
        linkPkg::packet_t pkt;
        l = rowLink[i];
        if (rowRestart[i]) begin
            restart[l] = 1'b1;
            @(negedge clk);
            restart[l] = 1'b0;
            seqCount[l] = 0;
        end
        case (rowKind[i])
            KData: begin
                r1 = $random(seed);
                r2 = $random(seed);
                pkt = makePacket({r1[3:0], r2});
            end
            KRaw: pkt = rowValue[i];
            default: pkt = makePacket(rowValue[i][`MEMLINK_WORD_WIDTH-1:0]);
        endcase
        inPacket[l] = pkt;
        dataReady[l] = 1'b1;
        if (!rowDrop[i]) begin
            modelStrobe(i, pkt);
        end
        // Gap 0 shares its strobe cycle with the next row
        if (rowGap[i] != 0) begin
            @(negedge clk);
            dataReady = '0;
            check({rowName[i], " overflow"}, rowOvf[i], overflow[l], rowFailed[i]);
            if (i > 0 && rowGap[i - 1] == 0) begin
                check({rowName[i - 1], " overflow"}, rowOvf[i - 1],
                      overflow[rowLink[i - 1]], rowFailed[i - 1]);
            end
            repeat (rowGap[i] - 1) @(negedge clk);
        end
    endtask

    function automatic bit anyPending();
        bit pending;
        pending = 1'b0;
        for (int l = 0; l < NumLinks; l++) begin
            if (head[l] != tail[l]) begin
                pending = 1'b1;
            end
        end
        return pending;
    endfunction

    // Bounded wait for outstanding responses
    task automatic drain();
        int waited;
        waited = 0;
        while (anyPending() && waited < MaxLatency) begin
            @(negedge clk);
            waited++;
        end
        for (int l = 0; l < NumLinks; l++) begin
            while (head[l] != tail[l]) begin
                $display("Timeout: test %s got no outValid on link %0d",
                         rowName[expRow[l][head[l] % Slots]], l);
                rowFailed[expRow[l][head[l] % Slots]] = 1'b1;
                head[l]++;
            end
        end
    endtask

    task automatic reportRows(input int upTo);
        while (reported < upTo) begin
            if (rowFailed[reported]) begin
                $display("Test %s failed", rowName[reported]);
                failCount++;
            end else begin
                $display("Test %s passed", rowName[reported]);
                passCount++;
            end
            reported++;
        end
    endtask

    task automatic checkReset();
        linkPkg::packet_t good;
        linkPkg::packet_t swapped;
        resetFailed = 1'b0;
        for (int l = 0; l < NumLinks; l++) begin
            check("reset outValid", 1'b0, outValid[l], resetFailed);
            check("reset overflow", 1'b0, overflow[l], resetFailed);
            check("reset outPacket", '0, outPacket[l], resetFailed);
        end
        good = makePacket(36'h1_2345_6789);
        swapped = good;
        swapped.first.tag = `MEMLINK_TAG_LO;
        swapped.second.tag = `MEMLINK_TAG_HI;
        // Valid, all-zero, then swapped tags
        inPacket[0] = good;
        inPacket[1] = good;
        @(negedge clk);
        check("reset validTags", 2'b11, inPacketIsValid, resetFailed);
        inPacket[0] = '0;
        inPacket[1] = '0;
        @(negedge clk);
        check("reset zeroTags", 2'b00, inPacketIsValid, resetFailed);
        inPacket[0] = swapped;
        inPacket[1] = swapped;
        @(negedge clk);
        check("reset swappedTags", 2'b00, inPacketIsValid, resetFailed);
        if (resetFailed) begin
            $display("Test reset failed");
            failCount++;
        end else begin
            $display("Test reset passed");
            passCount++;
        end
    endtask

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not complete", cycles);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    // Responses sampled a quarter period after the rising edge
    always @(posedge clk) begin
        #(HalfPeriod / 2);
        for (int l = 0; l < NumLinks; l++) begin
            if (!reset && outValid[l]) begin
                if (head[l] == tail[l]) begin
                    $display("Unexpected outValid on link %0d with nothing outstanding", l);
                    strayCount++;
                end else begin
                    monSlot = head[l] % Slots;
                    // Never written, nothing to compare
                    if (expKnown[l][monSlot]) begin
                        check(rowName[expRow[l][monSlot]], expPkt[l][monSlot],
                              outPacket[l], rowFailed[expRow[l][monSlot]]);
                    end
                    head[l]++;
                end
            end
        end
    end

    initial begin
        seed = 32'h78b9_5b9f;
        clk = 1'b0;
        reset = 1'b1;
        dataReady = '0;
        restart = '0;
        for (int l = 0; l < NumLinks; l++) begin
            inPacket[l] = '0;
        end
        buildTable();
        fork
            watchdog(numRows * maxGap + 100);
        join_none
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        checkReset();
        for (int i = 0; i < numRows; i++) begin
            applyRow(i);
            if (rowGap[i] >= SpacedGap) begin
                drain();
                reportRows(i + 1);
            end
        end
        drain();
        reportRows(numRows);
        $display("Passed %0d, failed %0d tests, %0d unexpected responses",
                 passCount, failCount, strayCount);
        if (failCount == 0 && strayCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+verilog
verilog/memPkg.sv
verilog/linkPkg.sv
verilog/linkMemPort.sv
verilog/memArbiter.sv
verilog/sharedRam.sv
verilog/memLinkTop.sv
sim/memLinkTb.sv

//--- Bender.yml
package:
  name: mem_link

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/memPkg.sv
      - verilog/linkPkg.sv
      - verilog/linkMemPort.sv
      - verilog/memArbiter.sv
      - verilog/sharedRam.sv
      - verilog/memLinkTop.sv
  - target: simulation
    files:
      - sim/memLinkTb.sv
